//--- build.f
memcopy_pkg.sv
memcopy_regs.sv
memcopy_read_stage.sv
memcopy_beat_fifo.sv
memcopy_write_stage.sv
memcopy_top.sv
tb_memcopy_mem.sv
tb_memcopy_checker.sv
tb_memcopy.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory-copy testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_memcopy -f build.f -o sim_memcopy
out=$(./obj_dir/sim_memcopy)
echo "$out"
echo "$out" | grep -q "all tests passed"

//--- tb_memcopy.sv
/* Testbench top of the memory-copy engine. Programs copies over the register
   bus against the memory model and checker, then prints the overall result. */
`default_nettype none

module tb_memcopy;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned TOTAL_WORDS = 16 + 37;
  // Per word up to 4 cycles to gnt and 4 to rvalid on a port
  localparam int unsigned WORST_DELAY = 8;
  localparam int unsigned TIMEOUT_CYCLES = TOTAL_WORDS * 2 * WORST_DELAY + 400;

  logic                       clk = 1'b0;
  logic                       arst_n;
  memcopy_pkg::reg_req_t      reg_req;
  memcopy_pkg::reg_rsp_t      reg_rsp;
  memcopy_pkg::obi_req_t      rd_req;
  memcopy_pkg::obi_resp_t     rd_resp;
  memcopy_pkg::obi_req_t      wr_req;
  memcopy_pkg::obi_resp_t     wr_resp;
  logic                       irq;
  logic                       stall;
  logic [7:0]                 rnd = '0;
  logic [15:0]                lfsr_q = 16'd50;
  memcopy_pkg::memcopy_cfg_t  job;
  logic                       job_start;
  logic [31:0]                cycle_cnt = '0;
  int unsigned                top_errors = 0;
  int unsigned                top_checks = 0;
  int unsigned                chk_errors;
  int unsigned                chk_checks;

  always #4 clk = ~clk;

  memcopy_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) memcopy_top_inst (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp),
    .rd_req_o  (rd_req),
    .rd_resp_i (rd_resp),
    .wr_req_o  (wr_req),
    .wr_resp_i (wr_resp),
    .irq_o     (irq)
  );

  tb_memcopy_mem mem_inst (
    .clk_i     (clk),
    .stall_i   (stall),
    .rnd_i     (rnd),
    .rd_req_i  (rd_req),
    .rd_resp_o (rd_resp),
    .wr_req_i  (wr_req),
    .wr_resp_o (wr_resp)
  );

  tb_memcopy_checker #(
    .MAX_OUTSTANDING (FIFO_DEPTH)
  ) checker_inst (
    .clk_i       (clk),
    .job_start_i (job_start),
    .job_i       (job),
    .rd_req_i    (rd_req),
    .rd_resp_i   (rd_resp),
    .wr_req_i    (wr_req),
    .wr_resp_i   (wr_resp),
    .irq_i       (irq),
    .errors_o    (chk_errors),
    .checks_o    (chk_checks)
  );

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Eight fresh bits per cycle for the memory delays
  always @(posedge clk) begin : rnd_gen
    logic [15:0] s;
    logic [7:0]  bits;
    s = lfsr_q;
    for (int i = 0; i < 8; i++) begin
      bits[i] = s[0];
      s       = lfsr_step(s);
    end
    lfsr_q <= s;
    rnd    <= bits;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 32'd1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    top_checks++;
    if (got !== exp) begin
      top_errors++;
      $display("FAIL %s: got %08h expected %08h", name, got, exp);
    end
  endtask

  // One access with the request at a rising edge and the response sampled mid cycle
  task automatic reg_access(input logic is_write, input logic [4:0] offset,
                            input logic [31:0] wdata, output memcopy_pkg::reg_rsp_t rsp);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: is_write, addr: offset, wdata: wdata};
    @(negedge clk);
    rsp = reg_rsp;
    check_value("reg_rsp_o.ready", {31'h0, rsp.ready}, 32'h1);
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic reg_write(input logic [4:0] offset, input logic [31:0] wdata, output logic err);
    memcopy_pkg::reg_rsp_t rsp;
    reg_access(1'b1, offset, wdata, rsp);
    err = rsp.error;
  endtask

  task automatic reg_read(input logic [4:0] offset, output logic [31:0] rdata, output logic err);
    memcopy_pkg::reg_rsp_t rsp;
    reg_access(1'b0, offset, '0, rsp);
    rdata = rsp.rdata;
    err   = rsp.error;
  endtask

  task automatic launch_copy(input logic [31:0] src, input logic [31:0] dst,
                             input logic [15:0] size);
    logic err;
    reg_write(memcopy_pkg::REG_SRC, src, err);
    check_value("SRC write error", {31'h0, err}, 32'h0);
    reg_write(memcopy_pkg::REG_DST, dst, err);
    reg_write(memcopy_pkg::REG_SIZE, {16'h0, size}, err);
    @(posedge clk);
    job       <= '{src: src, dst: dst, size: size};
    job_start <= 1'b1;
    @(posedge clk);
    job_start <= 1'b0;
    reg_write(memcopy_pkg::REG_CTRL, 32'h1, err);
    check_value("CTRL write error", {31'h0, err}, 32'h0);
  endtask

  task automatic wait_irq();
    do begin
      @(negedge clk);
    end while (irq !== 1'b1);
  endtask

  task automatic clear_done();
    logic        err;
    logic [31:0] rdata;
    reg_read(memcopy_pkg::REG_STATUS, rdata, err);
    check_value("STATUS after copy", rdata, 32'h2);
    reg_write(memcopy_pkg::REG_STATUS, 32'h2, err);
    @(negedge clk);
    check_value("irq_o", {31'h0, irq}, 32'h0);
    reg_read(memcopy_pkg::REG_STATUS, rdata, err);
    check_value("STATUS after clear", rdata, 32'h0);
  endtask

  initial begin
    logic        err;
    logic [31:0] rdata;
    arst_n    = 1'b0;
    reg_req   = '0;
    stall     = 1'b0;
    job       = '0;
    job_start = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("irq_o", {31'h0, irq}, 32'h0);
    check_value("rd_req_o.req", {31'h0, rd_req.req}, 32'h0);
    check_value("wr_req_o.req", {31'h0, wr_req.req}, 32'h0);
    reg_read(memcopy_pkg::REG_SRC, rdata, err);
    check_value("SRC after reset", rdata, 32'h0);
    reg_read(memcopy_pkg::REG_STATUS, rdata, err);
    check_value("STATUS after reset", rdata, 32'h0);

    // Register readback and an unmapped offset
    reg_write(memcopy_pkg::REG_SRC, 32'h0000_1000, err);
    reg_write(memcopy_pkg::REG_DST, 32'h0000_2000, err);
    reg_write(memcopy_pkg::REG_SIZE, 32'h0000_0010, err);
    reg_read(memcopy_pkg::REG_SRC, rdata, err);
    check_value("SRC", rdata, 32'h0000_1000);
    reg_read(memcopy_pkg::REG_DST, rdata, err);
    check_value("DST", rdata, 32'h0000_2000);
    reg_read(memcopy_pkg::REG_SIZE, rdata, err);
    check_value("SIZE", rdata, 32'h0000_0010);
    reg_read(5'h14, rdata, err);
    check_value("reg_rsp_o.error at 0x14", {31'h0, err}, 32'h1);

    // 16 words without stalls
    launch_copy(32'h0000_1000, 32'h0000_2000, 16'd16);
    @(negedge clk);
    check_value("rd_req_o.req after start", {31'h0, rd_req.req}, 32'h1);
    reg_read(memcopy_pkg::REG_STATUS, rdata, err);
    check_value("STATUS busy", rdata, 32'h1);
    wait_irq();
    clear_done();

    // 37 words with stalls and config frozen while busy
    @(posedge clk);
    stall <= 1'b1;
    launch_copy(32'h0001_0040, 32'h0003_0000, 16'd37);
    reg_write(memcopy_pkg::REG_SRC, 32'hDEAD_0000, err);
    check_value("SRC write error while busy", {31'h0, err}, 32'h1);
    reg_read(memcopy_pkg::REG_SRC, rdata, err);
    check_value("SRC while busy", rdata, 32'h0001_0040);
    reg_read(memcopy_pkg::REG_STATUS, rdata, err);
    check_value("STATUS busy", rdata, 32'h1);
    wait_irq();
    clear_done();

    // Empty copy completes two cycles after the CTRL write
    launch_copy(32'h0000_4000, 32'h0000_5000, 16'd0);
    @(negedge clk);
    check_value("irq_o one cycle after CTRL", {31'h0, irq}, 32'h0);
    @(negedge clk);
    check_value("irq_o two cycles after CTRL", {31'h0, irq}, 32'h1);
    repeat (4) @(posedge clk);
    clear_done();

    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", top_checks + chk_checks, top_errors + chk_errors);
    if (top_errors + chk_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_memcopy_checker.sv
/* Testbench checker of the copy engine. Compares every granted write with the
   reference copy, watches read credit and range, and checks the interrupt. */
`default_nettype none

module tb_memcopy_checker #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                       clk_i,
  input  logic                       job_start_i,
  input  memcopy_pkg::memcopy_cfg_t  job_i,
  input  memcopy_pkg::obi_req_t      rd_req_i,
  input  memcopy_pkg::obi_resp_t     rd_resp_i,
  input  memcopy_pkg::obi_req_t      wr_req_i,
  input  memcopy_pkg::obi_resp_t     wr_resp_i,
  input  logic                       irq_i,
  output int unsigned                errors_o,
  output int unsigned                checks_o
);

  timeunit 1ns;
  timeprecision 1ps;

  memcopy_pkg::memcopy_cfg_t job = '0;
  logic [31:0]               wr_idx = '0;
  logic [31:0]               wr_rsp_cnt = '0;
  logic [31:0]               rd_out = '0;
  logic [31:0]               sample = '0;
  logic [31:0]               last_rsp_sample = '0;
  logic                      irq_q = 1'b0;
  int unsigned               errors = 0;
  int unsigned               checks = 0;

  // Word k lands at dst + 4k and carries the pattern of src + 4k
  function automatic logic [63:0] expected_write(input memcopy_pkg::memcopy_cfg_t cfg,
                                                 input logic [31:0] k);
    logic [31:0] addr;
    logic [31:0] data;
    addr = cfg.dst + (k << 2);
    data = (cfg.src + (k << 2)) ^ 32'h5A5A_0000;
    return {addr, data};
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  always @(posedge clk_i) begin : watch
    logic [63:0] exp;
    logic [32:0] src_end;
    if (job_start_i) begin
      job        = job_i;
      wr_idx     = '0;
      wr_rsp_cnt = '0;
      rd_out     = '0;
    end
    src_end = {1'b0, job.src} + {15'h0, job.size, 2'b00};
    if (rd_req_i.req && ((rd_req_i.addr < job.src) || ({1'b0, rd_req_i.addr} >= src_end))) begin
      report_problem($sformatf("read request at %08h outside the source range", rd_req_i.addr));
    end
    if (rd_req_i.req && rd_resp_i.gnt) begin
      rd_out = rd_out + 32'd1;
      compare_field("rd_req_o.be", {28'h0, rd_req_i.be}, 32'hF);
      compare_field("rd_req_o.we", {31'h0, rd_req_i.we}, 32'h0);
    end
    if (rd_resp_i.rvalid) begin
      rd_out = rd_out - 32'd1;
    end
    if (rd_out > MAX_OUTSTANDING) begin
      report_problem($sformatf("%0d reads outstanding, more than allowed", rd_out));
    end
    if (wr_req_i.req && (wr_idx >= {16'h0, job.size})) begin
      report_problem("write request beyond the copy size");
    end else if (wr_req_i.req && wr_resp_i.gnt) begin
      exp = expected_write(job, wr_idx);
      compare_field("wr_req_o.addr", wr_req_i.addr, exp[63:32]);
      compare_field("wr_req_o.wdata", wr_req_i.wdata, exp[31:0]);
      compare_field("wr_req_o.be", {28'h0, wr_req_i.be}, 32'hF);
      compare_field("wr_req_o.we", {31'h0, wr_req_i.we}, 32'h1);
      wr_idx = wr_idx + 32'd1;
    end
    if (wr_resp_i.rvalid) begin
      wr_rsp_cnt      = wr_rsp_cnt + 32'd1;
      last_rsp_sample = sample;
    end
    // Completion must follow the last write response by one cycle
    if (irq_i && !irq_q) begin
      compare_field("write count", wr_idx, {16'h0, job.size});
      compare_field("write response count", wr_rsp_cnt, {16'h0, job.size});
      if ((job.size != '0) && (sample != last_rsp_sample + 32'd1)) begin
        report_problem("irq_o did not rise one cycle after the last write response");
      end
    end
    irq_q  = irq_i;
    sample = sample + 32'd1;
  end

  assign errors_o = errors;
  assign checks_o = checks;

endmodule

`default_nettype wire

//--- tb_memcopy_mem.sv
/* Testbench memory for both OBI master ports of the copy engine. Grants and
   answers with random stalls, read data follows the address pattern. */
`default_nettype none

module tb_memcopy_mem (
  input  logic                    clk_i,
  input  logic                    stall_i,
  input  logic [7:0]              rnd_i,
  input  memcopy_pkg::obi_req_t   rd_req_i,
  output memcopy_pkg::obi_resp_t  rd_resp_o,
  input  memcopy_pkg::obi_req_t   wr_req_i,
  output memcopy_pkg::obi_resp_t  wr_resp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  memcopy_pkg::obi_resp_t rd_resp = '0;
  memcopy_pkg::obi_resp_t wr_resp = '0;
  logic [31:0]            rd_pend [$];
  int unsigned            wr_pend = 0;
  logic [1:0]             rd_gnt_cnt = '0;
  logic [1:0]             rd_rsp_cnt = '0;
  logic [1:0]             wr_gnt_cnt = '0;
  logic [1:0]             wr_rsp_cnt = '0;

  // New delay once the previous request has gone, otherwise count down
  function automatic logic [1:0] next_delay(input logic reload, input logic [1:0] cnt,
                                            input logic [1:0] bits);
    if (reload) begin
      return stall_i ? bits : 2'd0;
    end
    return (cnt != 2'd0) ? cnt - 2'd1 : 2'd0;
  endfunction

  always @(posedge clk_i) begin : rd_port
    logic [1:0] gnt_cnt;
    logic       fire;
    if (rd_req_i.req && rd_resp.gnt) begin
      rd_pend.push_back(rd_req_i.addr ^ 32'h5A5A_0000);
    end
    gnt_cnt = next_delay(!rd_req_i.req || rd_resp.gnt, rd_gnt_cnt, rnd_i[1:0]);
    rd_gnt_cnt  <= gnt_cnt;
    rd_resp.gnt <= (gnt_cnt == 2'd0);
    // Responses leave in order
    fire = (rd_pend.size() != 0) && (rd_rsp_cnt == 2'd0);
    rd_resp.rvalid <= fire;
    if (fire) begin
      rd_resp.rdata <= rd_pend.pop_front();
    end
    rd_rsp_cnt <= next_delay(fire, rd_rsp_cnt, rnd_i[3:2]);
  end

  always @(posedge clk_i) begin : wr_port
    logic [1:0] gnt_cnt;
    logic       fire;
    fire = (wr_pend != 0) && (wr_rsp_cnt == 2'd0);
    wr_pend = wr_pend + ((wr_req_i.req && wr_resp.gnt) ? 1 : 0) - (fire ? 1 : 0);
    gnt_cnt = next_delay(!wr_req_i.req || wr_resp.gnt, wr_gnt_cnt, rnd_i[5:4]);
    wr_gnt_cnt     <= gnt_cnt;
    wr_resp.gnt    <= (gnt_cnt == 2'd0);
    wr_resp.rvalid <= fire;
    wr_resp.rdata  <= '0;
    wr_rsp_cnt     <= next_delay(fire, wr_rsp_cnt, rnd_i[7:6]);
  end

  assign rd_resp_o = rd_resp;
  assign wr_resp_o = wr_resp;

endmodule

`default_nettype wire

//--- memcopy_top.sv
/* Top level of the memory-copy engine. Joins register block, read stage,
   beat buffer and write stage, and sets the buffer depth for all of them. */
`default_nettype none

module memcopy_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  memcopy_pkg::reg_req_t   reg_req_i,
  output memcopy_pkg::reg_rsp_t   reg_rsp_o,
  output memcopy_pkg::obi_req_t   rd_req_o,
  input  memcopy_pkg::obi_resp_t  rd_resp_i,
  output memcopy_pkg::obi_req_t   wr_req_o,
  input  memcopy_pkg::obi_resp_t  wr_resp_i,
  output logic                    irq_o
);

  localparam int unsigned CNT_BITS = $clog2(FIFO_DEPTH) + 1;

  logic                        start;
  memcopy_pkg::memcopy_cfg_t   cfg;
  logic                        done;
  logic                        push;
  memcopy_pkg::memcopy_beat_t  push_beat;
  logic                        pop;
  logic                        fifo_valid;
  memcopy_pkg::memcopy_beat_t  fifo_beat;
  logic [CNT_BITS-1:0]         fifo_count;

  memcopy_regs memcopy_regs_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .done_i    (done),
    .start_o   (start),
    .cfg_o     (cfg),
    .irq_o     (irq_o)
  );

  memcopy_read_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) memcopy_read_stage_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start),
    .cfg_i        (cfg),
    .fifo_count_i (fifo_count),
    .rd_req_o     (rd_req_o),
    .rd_resp_i    (rd_resp_i),
    .push_o       (push),
    .beat_o       (push_beat)
  );

  memcopy_beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) memcopy_beat_fifo_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (push),
    .beat_i   (push_beat),
    .pop_i    (pop),
    .valid_o  (fifo_valid),
    .beat_o   (fifo_beat),
    .count_o  (fifo_count)
  );

  memcopy_write_stage memcopy_write_stage_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (start),
    .cfg_i     (cfg),
    .valid_i   (fifo_valid),
    .beat_i    (fifo_beat),
    .pop_o     (pop),
    .wr_req_o  (wr_req_o),
    .wr_resp_i (wr_resp_i),
    .done_o    (done)
  );

endmodule

`default_nettype wire

//--- memcopy_write_stage.sv
/* Write side of the copy engine. Turns buffered beats into OBI writes over the
   destination range and reports completion once the last write is answered. */
`default_nettype none

module memcopy_write_stage (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        start_i,
  input  memcopy_pkg::memcopy_cfg_t   cfg_i,
  input  logic                        valid_i,
  input  memcopy_pkg::memcopy_beat_t  beat_i,
  output logic                        pop_o,
  output memcopy_pkg::obi_req_t       wr_req_o,
  input  memcopy_pkg::obi_resp_t      wr_resp_i,
  output logic                        done_o
);

  memcopy_pkg::stage_state_e        state_q;
  logic                             req_q;
  logic                             took_last_q;
  logic                             zero_done_q;
  logic [memcopy_pkg::CNT_W-1:0]    resp_left_q;
  logic [memcopy_pkg::ADDR_W-1:0]   addr_q;
  logic [memcopy_pkg::DATA_W-1:0]   data_q;
  logic                             granted;
  logic                             last_resp;

  assign granted = req_q && wr_resp_i.gnt;

  // Take the head beat when the held request is free or leaves this cycle
  assign pop_o = (state_q == memcopy_pkg::RUN) && !took_last_q && valid_i
                 && (!req_q || wr_resp_i.gnt);

  assign last_resp = (state_q == memcopy_pkg::RUN) && wr_resp_i.rvalid
                     && (resp_left_q == memcopy_pkg::CNT_W'(1));
  assign done_o    = zero_done_q || last_resp;

  assign wr_req_o.req   = req_q;
  assign wr_req_o.we    = 1'b1;
  assign wr_req_o.be    = 4'hF;
  assign wr_req_o.addr  = addr_q;
  assign wr_req_o.wdata = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= memcopy_pkg::IDLE;
      req_q       <= 1'b0;
      took_last_q <= 1'b0;
      zero_done_q <= 1'b0;
      resp_left_q <= '0;
    end else begin
      // Empty copy completes straight from start
      zero_done_q <= start_i && (cfg_i.size == '0);
      if (start_i) begin
        state_q     <= (cfg_i.size != '0) ? memcopy_pkg::RUN : memcopy_pkg::IDLE;
        req_q       <= 1'b0;
        took_last_q <= 1'b0;
        resp_left_q <= cfg_i.size;
      end else begin
        if (pop_o) begin
          req_q <= 1'b1;
        end else if (granted) begin
          req_q <= 1'b0;
        end
        if (pop_o && beat_i.last) begin
          took_last_q <= 1'b1;
        end
        if ((state_q == memcopy_pkg::RUN) && wr_resp_i.rvalid) begin
          resp_left_q <= resp_left_q - 1'b1;
          if (last_resp) begin
            state_q <= memcopy_pkg::IDLE;
          end
        end
      end
    end
  end

  // Held write payload
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= cfg_i.dst;
    end else if (granted) begin
      addr_q <= addr_q + memcopy_pkg::ADDR_W'(4);
    end
    if (pop_o) begin
      data_q <= beat_i.data;
    end
  end

endmodule

`default_nettype wire

//--- memcopy_beat_fifo.sv
/* Circular beat buffer between read and write stage. Its occupancy count goes
   back to the read stage, which keeps it from overflowing. */
`default_nettype none

module memcopy_beat_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         push_i,
  input  memcopy_pkg::memcopy_beat_t   beat_i,
  input  logic                         pop_i,
  output logic                         valid_o,
  output memcopy_pkg::memcopy_beat_t   beat_o,
  output logic [$clog2(FIFO_DEPTH):0]  count_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  memcopy_pkg::memcopy_beat_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [PTR_W:0]             count_q;
  logic                       do_push;
  logic                       do_pop;

  assign do_pop  = pop_i && (count_q != '0);
  assign do_push = push_i && (count_q != (PTR_W + 1)'(FIFO_DEPTH));

  assign valid_o = (count_q != '0);
  assign beat_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= beat_i;
    end
  end

endmodule

`default_nettype wire

//--- memcopy_read_stage.sv
/* Read side of the copy engine. Walks the source range with OBI reads while
   read credit remains and hands every read response to the beat buffer. */
`default_nettype none

module memcopy_read_stage #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         start_i,
  input  memcopy_pkg::memcopy_cfg_t    cfg_i,
  input  logic [$clog2(FIFO_DEPTH):0]  fifo_count_i,
  output memcopy_pkg::obi_req_t        rd_req_o,
  input  memcopy_pkg::obi_resp_t       rd_resp_i,
  output logic                         push_o,
  output memcopy_pkg::memcopy_beat_t   beat_o
);

  localparam int unsigned CNT_BITS = $clog2(FIFO_DEPTH) + 1;

  memcopy_pkg::stage_state_e        state_q;
  logic [memcopy_pkg::ADDR_W-1:0]   addr_q;
  logic [memcopy_pkg::CNT_W-1:0]    issue_left_q;
  logic [memcopy_pkg::CNT_W-1:0]    resp_left_q;
  logic [CNT_BITS-1:0]              outstanding_q;
  logic [CNT_BITS:0]                credit_used;
  logic                             issue;
  logic                             granted;

  // Reads in flight plus buffered beats must stay below the buffer depth
  assign credit_used = {1'b0, outstanding_q} + {1'b0, fifo_count_i};

  assign issue = (state_q == memcopy_pkg::RUN) && (issue_left_q != '0)
                 && (credit_used < (CNT_BITS + 1)'(FIFO_DEPTH));
  assign granted = issue && rd_resp_i.gnt;

  assign rd_req_o.req   = issue;
  assign rd_req_o.we    = 1'b0;
  assign rd_req_o.be    = 4'hF;
  assign rd_req_o.addr  = addr_q;
  assign rd_req_o.wdata = '0;

  // One beat per response with last counted on responses
  assign push_o      = rd_resp_i.rvalid && (state_q == memcopy_pkg::RUN);
  assign beat_o.data = rd_resp_i.rdata;
  assign beat_o.last = (resp_left_q == memcopy_pkg::CNT_W'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= memcopy_pkg::IDLE;
      issue_left_q  <= '0;
      resp_left_q   <= '0;
      outstanding_q <= '0;
    end else if (start_i) begin
      state_q       <= (cfg_i.size != '0) ? memcopy_pkg::RUN : memcopy_pkg::IDLE;
      issue_left_q  <= cfg_i.size;
      resp_left_q   <= cfg_i.size;
      outstanding_q <= '0;
    end else if (state_q == memcopy_pkg::RUN) begin
      if (granted) begin
        issue_left_q <= issue_left_q - 1'b1;
      end
      case ({granted, push_o})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: ;
      endcase
      if (push_o) begin
        resp_left_q <= resp_left_q - 1'b1;
        if (beat_o.last) begin
          state_q <= memcopy_pkg::IDLE;
        end
      end
    end
  end

  // Source address advanced per granted read
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= cfg_i.src;
    end else if (granted) begin
      addr_q <= addr_q + memcopy_pkg::ADDR_W'(4);
    end
  end

endmodule

`default_nettype wire

//--- memcopy_regs.sv
/* Register-bus slave of the copy engine. Holds source, destination and size,
   launches a copy on a CTRL write and keeps busy, done and the level interrupt. */
`default_nettype none

module memcopy_regs (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  memcopy_pkg::reg_req_t     reg_req_i,
  output memcopy_pkg::reg_rsp_t     reg_rsp_o,
  input  logic                      done_i,
  output logic                      start_o,
  output memcopy_pkg::memcopy_cfg_t cfg_o,
  output logic                      irq_o
);

  memcopy_pkg::memcopy_cfg_t cfg_q;
  logic                      busy_q;
  logic                      done_q;
  logic                      addr_ok;
  logic                      cfg_write;
  logic                      wr_refused;
  logic                      wr_en;

  // Offset decode
  always_comb begin
    addr_ok   = 1'b1;
    cfg_write = 1'b0;
    case (reg_req_i.addr)
      memcopy_pkg::REG_SRC,
      memcopy_pkg::REG_DST,
      memcopy_pkg::REG_SIZE,
      memcopy_pkg::REG_CTRL:   cfg_write = reg_req_i.write;
      memcopy_pkg::REG_STATUS: cfg_write = 1'b0;
      default:                 addr_ok   = 1'b0;
    endcase
  end

  // Config and control are frozen while a copy runs
  assign wr_refused = reg_req_i.valid && cfg_write && busy_q;
  assign wr_en      = reg_req_i.valid && reg_req_i.write && addr_ok && !wr_refused;

  assign start_o = wr_en && (reg_req_i.addr == memcopy_pkg::REG_CTRL) && reg_req_i.wdata[0];

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = reg_req_i.valid && (!addr_ok || wr_refused);

  always_comb begin
    case (reg_req_i.addr)
      memcopy_pkg::REG_SRC:  reg_rsp_o.rdata = cfg_q.src;
      memcopy_pkg::REG_DST:  reg_rsp_o.rdata = cfg_q.dst;
      memcopy_pkg::REG_SIZE: begin
        reg_rsp_o.rdata = {{(memcopy_pkg::DATA_W - memcopy_pkg::CNT_W){1'b0}}, cfg_q.size};
      end
      memcopy_pkg::REG_STATUS: begin
        reg_rsp_o.rdata = {{(memcopy_pkg::DATA_W - 2){1'b0}}, done_q, busy_q};
      end
      default:               reg_rsp_o.rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (wr_en) begin
        case (reg_req_i.addr)
          memcopy_pkg::REG_SRC:  cfg_q.src  <= reg_req_i.wdata;
          memcopy_pkg::REG_DST:  cfg_q.dst  <= reg_req_i.wdata;
          memcopy_pkg::REG_SIZE: cfg_q.size <= reg_req_i.wdata[memcopy_pkg::CNT_W-1:0];
          default: ;
        endcase
      end

      if (start_o) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end

      // Done is sticky until the host writes 1 to STATUS bit 1
      if (done_i) begin
        done_q <= 1'b1;
      end else if (wr_en && (reg_req_i.addr == memcopy_pkg::REG_STATUS)
                   && reg_req_i.wdata[1]) begin
        done_q <= 1'b0;
      end
    end
  end

  assign cfg_o = cfg_q;
  assign irq_o = done_q;

endmodule

`default_nettype wire

//--- memcopy_pkg.sv
/* Widths, bus structs, register map and stage states of the memory-copy engine.
   RTL and testbench both refer to these by scoped name. */
`default_nettype none

package memcopy_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned CNT_W  = 16;

  // Register bus request with one access per cycle
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [4:0]        addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              ready;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  // OBI style master port
  typedef struct packed {
    logic              req;
    logic              we;
    logic [3:0]        be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

  // One word on its way from read stage to write stage
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } memcopy_beat_t;

  // Copy job as programmed by the host
  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [CNT_W-1:0]  size;
  } memcopy_cfg_t;

  // Byte offsets on the register bus
  typedef enum logic [4:0] {
    REG_SRC    = 5'h00,
    REG_DST    = 5'h04,
    REG_SIZE   = 5'h08,
    REG_CTRL   = 5'h0C,
    REG_STATUS = 5'h10
  } memcopy_reg_e;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } stage_state_e;

endpackage

`default_nettype wire
